/* ice_consts.svh */
`ifndef ICE_CONSTS_SVH
`define ICE_CONSTS_SVH

// screen and map geometry
`define SCREEN_W            551
`define SCREEN_H            401
`define GROUND_NUM          50
`define BLOCK_W             25
`define BLOCK_H             25
`define FLOOR_Y             400
`define PLAT_LOW_Y          310
`define PLAT_HIGH_Y         230

// player box and spawn point
`define PLAYER_W            16
`define PLAYER_H            16
`define PLAYER_X0           10
`define PLAYER_Y0           267

// snowflakes sit in one column
`define SNOW_NUM            15
`define SNOW_X              144
`define SNOW_PITCH          26
`define SNOW_W              24
`define SNOW_H              26

// monsters
`define MONSTER_NUM         2
`define MONSTER0_X          250
`define MONSTER0_Y          197
`define MONSTER1_X          300
`define MONSTER1_Y          384
`define MONSTER_W           16
`define MONSTER_H           16
`define HEALTH_INIT         3

// scan codes
`define KEY_W               8'h1D
`define KEY_A               8'h1C
`define KEY_D               8'h23
`define KEY_R               8'h2D

// motion, in clock cycles per pixel
`define MOVE_PERIOD         4
`define JUMP_PERIOD_START   2
`define JUMP_PERIOD_END     6
`define FALL_PERIOD_START   6
`define FALL_PERIOD_MIN     2
// pixels travelled between two period changes
`define RAMP_PIXELS         4

`endif

/* ice_geom_pkg.sv */
`default_nettype none

package ice_geom_pkg;

    typedef logic [9:0] xcoord_t;
    typedef logic [8:0] ycoord_t;

    // top-left corner of an object
    typedef struct packed {
        xcoord_t x;
        ycoord_t y;
    } pos_t;

    // player touches a block on that side
    typedef struct packed {
        logic below;
        logic above;
        logic right;
        logic left;
    } contact_t;

    // true when [a, a+a_len) and [b, b+b_len) share a pixel
    function automatic logic span_overlap(input int a, input int a_len,
                                          input int b, input int b_len);
        return (a < b + b_len) && (b < a + a_len);
    endfunction

endpackage

`default_nettype wire

/* ice_game_pkg.sv */
`default_nettype none

package ice_game_pkg;

    typedef enum logic [1:0] {
        GS_START = 2'd0,
        GS_PLAY  = 2'd1,
        GS_WIN   = 2'd2,
        GS_LOSE  = 2'd3
    } game_state_e;

    // one make or break code from the keyboard
    typedef struct packed {
        logic [7:0] code;
        logic       released;
    } key_event_t;

    // direction keys currently held
    typedef struct packed {
        logic up;
        logic left;
        logic right;
    } move_cmd_t;

    typedef logic [3:0] score_t;
    typedef logic [3:0] health_t;

endpackage

`default_nettype wire

/* key_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module key_decoder (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  ice_game_pkg::key_event_t  key_i,
    input  logic                      key_valid_i,
    output logic                      key_ready_o,
    output ice_game_pkg::move_cmd_t   move_cmd_o,
    output logic                      restart_o
);
    import ice_game_pkg::*;

    key_event_t evt_q;
    logic       evt_vld_q;
    logic       accept;

    // single holding slot, so ready drops while an event is applied
    assign key_ready_o = !evt_vld_q;
    assign accept      = key_valid_i && key_ready_o;

    always_ff @(posedge clk) begin
        if (accept) begin
            evt_q <= key_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            evt_vld_q  <= 1'b0;
            move_cmd_o <= '0;
            restart_o  <= 1'b0;
        end else begin
            evt_vld_q <= accept;
            restart_o <= 1'b0;
            if (evt_vld_q) begin
                case (evt_q.code)
                    `KEY_W: move_cmd_o.up    <= !evt_q.released;
                    `KEY_A: move_cmd_o.left  <= !evt_q.released;
                    `KEY_D: move_cmd_o.right <= !evt_q.released;
                    `KEY_R: begin
                        // restart also drops any held direction
                        if (!evt_q.released) begin
                            restart_o  <= 1'b1;
                            move_cmd_o <= '0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* ground_map.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module ground_map (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ice_geom_pkg::pos_t      player_pos_i,
    input  logic                    restart_i,
    output ice_geom_pkg::contact_t  contact_o,
    output logic [`GROUND_NUM-1:0]  iced_o,
    output logic                    all_iced_o
);
    import ice_geom_pkg::*;

    // row segments of the map, left to right
    localparam int FLOOR_CNT = 22;
    localparam int LOW_CNT   = 7;
    localparam int LOW_A_X   = 100;
    localparam int LOW_B_X   = 300;
    localparam int HIGH_X    = 200;

    function automatic int block_x(input int i);
        if (i < FLOOR_CNT) begin
            return `BLOCK_W * i;
        end else if (i < FLOOR_CNT + LOW_CNT) begin
            return LOW_A_X + `BLOCK_W * (i - FLOOR_CNT);
        end else if (i < FLOOR_CNT + 2 * LOW_CNT) begin
            return LOW_B_X + `BLOCK_W * (i - FLOOR_CNT - LOW_CNT);
        end
        return HIGH_X + `BLOCK_W * (i - FLOOR_CNT - 2 * LOW_CNT);
    endfunction

    function automatic int block_y(input int i);
        if (i < FLOOR_CNT) begin
            return `FLOOR_Y;
        end else if (i < FLOOR_CNT + 2 * LOW_CNT) begin
            return `PLAT_LOW_Y;
        end
        return `PLAT_HIGH_Y;
    endfunction

    int                     px;
    int                     py;
    logic [`GROUND_NUM-1:0] hit_below;
    logic [`GROUND_NUM-1:0] hit_above;
    logic [`GROUND_NUM-1:0] hit_right;
    logic [`GROUND_NUM-1:0] hit_left;

    assign px = int'(player_pos_i.x);
    assign py = int'(player_pos_i.y);

    // edge contact per block, faces flush and the other axis overlapping
    for (genvar i = 0; i < `GROUND_NUM; i++) begin : g_block
        localparam int BX = block_x(i);
        localparam int BY = block_y(i);
        logic h_ovl;
        logic v_ovl;

        assign h_ovl        = span_overlap(px, `PLAYER_W, BX, `BLOCK_W);
        assign v_ovl        = span_overlap(py, `PLAYER_H, BY, `BLOCK_H);
        assign hit_below[i] = h_ovl && (py + `PLAYER_H == BY);
        assign hit_above[i] = h_ovl && (py == BY + `BLOCK_H);
        assign hit_right[i] = v_ovl && (px + `PLAYER_W == BX);
        assign hit_left[i]  = v_ovl && (px == BX + `BLOCK_W);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            contact_o <= '0;
            iced_o    <= '0;
        end else begin
            contact_o <= '{below: |hit_below, above: |hit_above,
                           right: |hit_right, left: |hit_left};
            // standing on a block ices it for good
            iced_o    <= iced_o | hit_below;
        end
    end

    assign all_iced_o = &iced_o;

endmodule

`default_nettype wire

/* player_motion.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module player_motion (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  ice_game_pkg::game_state_e  game_state_i,
    input  ice_game_pkg::move_cmd_t    move_cmd_i,
    input  ice_geom_pkg::contact_t     contact_i,
    input  logic                       restart_i,
    output ice_geom_pkg::pos_t         player_pos_o
);
    import ice_geom_pkg::*;
    import ice_game_pkg::*;

    pos_t       pos_q;
    logic [3:0] h_cnt_q;
    logic [3:0] v_cnt_q;
    logic [3:0] jump_per_q;
    logic [3:0] fall_per_q;
    // pixels since the last period change
    logic [3:0] ramp_q;
    logic       jump_q;
    logic       moved_q;

    logic       playing;
    logic       go_left;
    logic       go_right;
    logic       h_run;
    logic       rising;
    logic       falling;
    logic       v_run;
    logic [3:0] v_per;
    logic       h_due;
    logic       v_due;
    logic       h_step;
    logic       v_step;
    logic       jump_go;

    assign playing  = game_state_i == GS_PLAY;
    // right wins when both directions are held
    assign go_left  = move_cmd_i.left && !move_cmd_i.right && !contact_i.left;
    assign go_right = move_cmd_i.right && !contact_i.right;
    assign h_run    = playing && (go_left || go_right);
    assign rising   = playing && jump_q && !contact_i.above;
    assign falling  = playing && !jump_q && !contact_i.below;
    assign v_run    = rising || falling;
    assign v_per    = jump_q ? jump_per_q : fall_per_q;
    assign h_due    = h_cnt_q == 4'(`MOVE_PERIOD - 1);
    assign v_due    = v_cnt_q == v_per - 4'd1;

    // one pixel per step, then a quiet cycle so contact catches up
    assign h_step  = h_run && h_due && !moved_q;
    assign v_step  = v_run && v_due && !moved_q && !h_step;
    assign jump_go = playing && !jump_q && move_cmd_i.up && contact_i.below && !moved_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            pos_q      <= '{x: xcoord_t'(`PLAYER_X0), y: ycoord_t'(`PLAYER_Y0)};
            h_cnt_q    <= '0;
            v_cnt_q    <= '0;
            jump_per_q <= 4'(`JUMP_PERIOD_START);
            fall_per_q <= 4'(`FALL_PERIOD_START);
            ramp_q     <= '0;
            jump_q     <= 1'b0;
            moved_q    <= 1'b0;
        end else begin
            moved_q <= h_step || v_step;

            // horizontal prescaler waits at its last count while blocked
            if (!h_run) begin
                h_cnt_q <= '0;
            end else if (h_step) begin
                h_cnt_q <= '0;
                pos_q.x <= go_left ? pos_q.x - 10'd1 : pos_q.x + 10'd1;
            end else if (!h_due) begin
                h_cnt_q <= h_cnt_q + 4'd1;
            end

            if (jump_go) begin
                jump_q     <= 1'b1;
                jump_per_q <= 4'(`JUMP_PERIOD_START);
                ramp_q     <= '0;
                v_cnt_q    <= '0;
            end else if (jump_q && contact_i.above) begin
                // head hit a block, drop from here
                jump_q  <= 1'b0;
                ramp_q  <= '0;
                v_cnt_q <= '0;
            end else if (!v_run) begin
                v_cnt_q    <= '0;
                ramp_q     <= '0;
                fall_per_q <= 4'(`FALL_PERIOD_START);
            end else if (v_step) begin
                v_cnt_q <= '0;
                pos_q.y <= rising ? pos_q.y - 9'd1 : pos_q.y + 9'd1;
                if (ramp_q == 4'(`RAMP_PIXELS - 1)) begin
                    ramp_q <= '0;
                    // rising slows down, falling speeds up
                    if (rising) begin
                        jump_per_q <= jump_per_q + 4'd1;
                        if (jump_per_q + 4'd1 == 4'(`JUMP_PERIOD_END)) begin
                            jump_q <= 1'b0;
                        end
                    end else if (fall_per_q > 4'(`FALL_PERIOD_MIN)) begin
                        fall_per_q <= fall_per_q - 4'd1;
                    end
                end else begin
                    ramp_q <= ramp_q + 4'd1;
                end
            end else if (!v_due) begin
                v_cnt_q <= v_cnt_q + 4'd1;
            end
        end
    end

    assign player_pos_o = pos_q;

endmodule

`default_nettype wire

/* pickup_tracker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module pickup_tracker (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  ice_geom_pkg::pos_t         player_pos_i,
    input  ice_game_pkg::game_state_e  game_state_i,
    input  logic                       restart_i,
    output ice_game_pkg::score_t       score_o,
    output ice_game_pkg::health_t      health_o,
    output logic [`MONSTER_NUM-1:0]    monster_frozen_o
);
    import ice_geom_pkg::*;
    import ice_game_pkg::*;

    int                      px;
    int                      py;
    logic                    playing;
    logic                    snow_col;
    logic [`SNOW_NUM-1:0]    snow_hit;
    logic [`SNOW_NUM-1:0]    snow_got_q;
    logic [`SNOW_NUM-1:0]    snow_new;
    logic [`MONSTER_NUM-1:0] mon_hit;
    logic [`MONSTER_NUM-1:0] mon_top;
    logic [`MONSTER_NUM-1:0] mon_hit_q;
    logic [`MONSTER_NUM-1:0] mon_new;
    logic [`MONSTER_NUM-1:0] mon_freeze;
    score_t                  snow_cnt;
    health_t                 dmg_cnt;

    assign px       = int'(player_pos_i.x);
    assign py       = int'(player_pos_i.y);
    assign playing  = game_state_i == GS_PLAY;
    assign snow_col = span_overlap(px, `PLAYER_W, `SNOW_X, `SNOW_W);

    for (genvar i = 0; i < `SNOW_NUM; i++) begin : g_snow
        assign snow_hit[i] = snow_col
            && span_overlap(py, `PLAYER_H, `SNOW_PITCH * i, `SNOW_H);
    end

    for (genvar i = 0; i < `MONSTER_NUM; i++) begin : g_monster
        localparam int MX = (i == 0) ? `MONSTER0_X : `MONSTER1_X;
        localparam int MY = (i == 0) ? `MONSTER0_Y : `MONSTER1_Y;
        logic h_ovl;

        assign h_ovl      = span_overlap(px, `PLAYER_W, MX, `MONSTER_W);
        assign mon_hit[i] = h_ovl && span_overlap(py, `PLAYER_H, MY, `MONSTER_H);
        // landing on its head freezes it
        assign mon_top[i] = h_ovl && (py + `PLAYER_H == MY);
    end

    always_comb begin
        snow_new   = playing ? (snow_hit & ~snow_got_q) : '0;
        mon_new    = playing ? (mon_hit & ~mon_hit_q & ~monster_frozen_o) : '0;
        mon_freeze = playing ? mon_top : '0;
        snow_cnt   = '0;
        dmg_cnt    = '0;
        // the player can span two snowflakes at once
        for (int i = 0; i < `SNOW_NUM; i++) begin
            snow_cnt = snow_cnt + score_t'(snow_new[i]);
        end
        for (int i = 0; i < `MONSTER_NUM; i++) begin
            dmg_cnt = dmg_cnt + health_t'(mon_new[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || restart_i) begin
            snow_got_q       <= '0;
            mon_hit_q        <= '0;
            monster_frozen_o <= '0;
            score_o          <= '0;
            health_o         <= health_t'(`HEALTH_INIT);
        end else begin
            // overlap history gives the rising edge for damage
            mon_hit_q        <= mon_hit;
            snow_got_q       <= snow_got_q | snow_new;
            monster_frozen_o <= monster_frozen_o | mon_freeze;
            score_o          <= score_o + snow_cnt;
            health_o         <= (dmg_cnt >= health_o) ? '0 : health_o - dmg_cnt;
        end
    end

endmodule

`default_nettype wire

/* game_fsm.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module game_fsm (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       restart_i,
    input  ice_game_pkg::health_t      health_i,
    input  logic                       all_iced_i,
    output ice_game_pkg::game_state_e  game_state_o
);
    import ice_game_pkg::*;

    game_state_e state_q;
    game_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            GS_START: begin
                if (restart_i) begin
                    state_d = GS_PLAY;
                end
            end
            GS_PLAY: begin
                // losing takes precedence over a last iced block
                if (health_i == '0) begin
                    state_d = GS_LOSE;
                end else if (all_iced_i) begin
                    state_d = GS_WIN;
                end
            end
            GS_WIN, GS_LOSE: begin
                if (restart_i) begin
                    state_d = GS_START;
                end
            end
            default: state_d = GS_START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= GS_START;
        end else begin
            state_q <= state_d;
        end
    end

    assign game_state_o = state_q;

endmodule

`default_nettype wire

/* ice_game_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module ice_game_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  ice_game_pkg::key_event_t   key_i,
    input  logic                       key_valid_i,
    output logic                       key_ready_o,
    output ice_geom_pkg::pos_t         player_pos_o,
    output ice_game_pkg::score_t       score_o,
    output ice_game_pkg::health_t      health_o,
    output logic [`GROUND_NUM-1:0]     iced_o,
    output logic [`MONSTER_NUM-1:0]    monster_frozen_o,
    output ice_game_pkg::game_state_e  game_state_o
);
    import ice_geom_pkg::*;
    import ice_game_pkg::*;

    move_cmd_t move_cmd;
    contact_t  contact;
    logic      restart_pulse;
    logic      all_iced;

    key_decoder u_key_decoder (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .key_i       (key_i),
        .key_valid_i (key_valid_i),
        .key_ready_o (key_ready_o),
        .move_cmd_o  (move_cmd),
        .restart_o   (restart_pulse)
    );

    ground_map u_ground_map (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .player_pos_i (player_pos_o),
        .restart_i    (restart_pulse),
        .contact_o    (contact),
        .iced_o       (iced_o),
        .all_iced_o   (all_iced)
    );

    player_motion u_player_motion (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .game_state_i (game_state_o),
        .move_cmd_i   (move_cmd),
        .contact_i    (contact),
        .restart_i    (restart_pulse),
        .player_pos_o (player_pos_o)
    );

    pickup_tracker u_pickup_tracker (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .player_pos_i     (player_pos_o),
        .game_state_i     (game_state_o),
        .restart_i        (restart_pulse),
        .score_o          (score_o),
        .health_o         (health_o),
        .monster_frozen_o (monster_frozen_o)
    );

    game_fsm u_game_fsm (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .restart_i    (restart_pulse),
        .health_i     (health_o),
        .all_iced_i   (all_iced),
        .game_state_o (game_state_o)
    );

endmodule

`default_nettype wire

/* tb_ice_game.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ice_consts.svh"

module tb_ice_game;
    import ice_geom_pkg::*;
    import ice_game_pkg::*;

    localparam int FLOOR_BLOCKS   = 22;
    localparam int REST_Y         = `FLOOR_Y - `PLAYER_H;
    localparam int FALL_PIXELS    = REST_Y - `PLAYER_Y0;
    localparam int FALL_LIMIT     = FALL_PIXELS * (`FALL_PERIOD_START + 1) + 10;
    localparam int STEP_CYCLES    = `MOVE_PERIOD + 1;
    // walking never covers more than twice the screen width
    localparam int WALK_PIXELS    = 2 * `SCREEN_W;
    localparam int TIMEOUT_CYCLES = (2 * FALL_PIXELS + WALK_PIXELS) * `FALL_PERIOD_START + 2000;
    localparam int PROBE_X        = 0;
    localparam int PROBE_Y        = 1;
    localparam int PROBE_HEALTH   = 2;

    logic                    clk;
    logic                    rst_n_i;
    key_event_t              key_i;
    logic                    key_valid_i;
    logic                    key_ready_o;
    pos_t                    player_pos;
    score_t                  score;
    health_t                 health;
    logic [`GROUND_NUM-1:0]  iced;
    logic [`MONSTER_NUM-1:0] frozen;
    game_state_e             game_state;

    int   n_checks;
    int   n_errors;
    int   cycle_cnt = 0;
    int   min_y;
    int   step_dx;
    int   step_dy;
    bit   watch_steps;
    pos_t prev_pos;

    ice_game_top u_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .key_i            (key_i),
        .key_valid_i      (key_valid_i),
        .key_ready_o      (key_ready_o),
        .player_pos_o     (player_pos),
        .score_o          (score),
        .health_o         (health),
        .iced_o           (iced),
        .monster_frozen_o (frozen),
        .game_state_o     (game_state)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // player moves at most one pixel per cycle
    always @(negedge clk) begin
        step_dx = int'(player_pos.x) - int'(prev_pos.x);
        step_dy = int'(player_pos.y) - int'(prev_pos.y);
        if (watch_steps) begin
            assert (step_dx * step_dx + step_dy * step_dy <= 1) else begin
                n_errors++;
                $display("ERROR: player moved from (%0d,%0d) to (%0d,%0d) in one cycle",
                         prev_pos.x, prev_pos.y, player_pos.x, player_pos.y);
            end
        end
        if (int'(player_pos.y) < min_y) begin
            min_y = int'(player_pos.y);
        end
        prev_pos = player_pos;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        n_checks++;
        assert (got === expected) else begin
            n_errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("ERROR: %s", what);
        end
    endtask

    // floor blocks under a player resting at x
    function automatic logic [`GROUND_NUM-1:0] iced_under(input int x);
        logic [`GROUND_NUM-1:0] bits;
        bits = '0;
        for (int i = 0; i < FLOOR_BLOCKS; i++) begin
            bits[i] = (x < `BLOCK_W * i + `BLOCK_W) && (`BLOCK_W * i < x + `PLAYER_W);
        end
        return bits;
    endfunction

    // snowflakes whose rows meet a player at height y
    function automatic int snowflakes_beside(input int y);
        int n;
        n = 0;
        for (int i = 0; i < `SNOW_NUM; i++) begin
            if ((y < `SNOW_PITCH * i + `SNOW_H) && (`SNOW_PITCH * i < y + `PLAYER_H)) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int probe(input int which);
        case (which)
            PROBE_X: return int'(player_pos.x);
            PROBE_Y: return int'(player_pos.y);
            default: return int'(health);
        endcase
    endfunction

    task automatic wait_for(input int which, input int target, input int limit,
                            input string what);
        int n;
        n = 0;
        while (probe(which) != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        require_true(probe(which) == target,
                     $sformatf("%s not reached within %0d cycles", what, limit));
    endtask

    // holds one event until accepted and leaves valid high
    task automatic send_key(input logic [7:0] code, input logic released);
        key_i.code     = code;
        key_i.released = released;
        key_valid_i    = 1'b1;
        while (!key_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic put_key(input logic [7:0] code, input logic released);
        send_key(code, released);
        key_valid_i = 1'b0;
    endtask

    task automatic watch_still(input int cycles, input string what);
        pos_t start;
        logic moved;
        start = player_pos;
        moved = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            moved = moved | (player_pos !== start);
        end
        require_true(!moved, what);
    endtask

    task automatic expect_reset_values();
        compare_value("game_state_o", game_state, GS_START);
        compare_value("score_o", score, 0);
        compare_value("health_o", health, `HEALTH_INIT);
        compare_value("player_pos_o.x", player_pos.x, `PLAYER_X0);
        compare_value("player_pos_o.y", player_pos.y, `PLAYER_Y0);
        compare_value("iced_o", iced, 0);
        compare_value("monster_frozen_o", frozen, 0);
        compare_value("key_ready_o", key_ready_o, 1);
    endtask

    task automatic reset_and_start();
        expect_reset_values();
        put_key(`KEY_R, 1'b0);
        compare_value("key_ready_o", key_ready_o, 0);
        @(negedge clk);
        compare_value("key_ready_o", key_ready_o, 1);
        compare_value("game_state_o", game_state, GS_START);
        @(negedge clk);
        compare_value("game_state_o", game_state, GS_PLAY);
    endtask

    task automatic landing_and_icing();
        watch_steps = 1'b1;
        wait_for(PROBE_Y, REST_Y, FALL_LIMIT, "resting height");
        watch_still(2 * `FALL_PERIOD_START, "player kept moving after landing");
        compare_value("player_pos_o.x", player_pos.x, `PLAYER_X0);
        compare_value("iced_o", iced, iced_under(`PLAYER_X0));
    endtask

    task automatic walk_and_release();
        int x0;
        int xs;
        x0 = player_pos.x;
        put_key(`KEY_D, 1'b0);
        wait_for(PROBE_X, x0 + 20, 20 * STEP_CYCLES + 10, "x while holding D");
        put_key(`KEY_D, 1'b1);
        @(negedge clk);
        watch_still(4 * `MOVE_PERIOD, "x changed after D was released");
        xs = player_pos.x;
        put_key(`KEY_A, 1'b0);
        wait_for(PROBE_X, xs - 10, 10 * STEP_CYCLES + 10, "x while holding A");
        put_key(`KEY_A, 1'b1);
        @(negedge clk);
    endtask

    task automatic snowflake_score();
        int limit;
        limit = (`SNOW_X + `SNOW_W - int'(player_pos.x)) * STEP_CYCLES + 10;
        put_key(`KEY_D, 1'b0);
        wait_for(PROBE_X, `SNOW_X + `SNOW_W, limit, "x past the snowflake column");
        put_key(`KEY_D, 1'b1);
        repeat (2) @(negedge clk);
        compare_value("score_o", score, snowflakes_beside(REST_Y));
    endtask

    task automatic monster_damage();
        int limit;
        for (int k = 1; k <= `HEALTH_INIT; k++) begin
            limit = (`MONSTER1_X - int'(player_pos.x)) * STEP_CYCLES + 20;
            put_key(`KEY_D, 1'b0);
            wait_for(PROBE_HEALTH, `HEALTH_INIT - k, limit, "health after monster contact");
            put_key(`KEY_D, 1'b1);
            repeat (2 * STEP_CYCLES) @(negedge clk);
            compare_value("health_o", health, `HEALTH_INIT - k);
            if (k < `HEALTH_INIT) begin
                // back off until the boxes no longer overlap
                limit = (int'(player_pos.x) - `MONSTER1_X + `PLAYER_W + 3) * STEP_CYCLES + 10;
                put_key(`KEY_A, 1'b0);
                wait_for(PROBE_X, `MONSTER1_X - `PLAYER_W - 2, limit, "x while backing off");
                put_key(`KEY_A, 1'b1);
                @(negedge clk);
            end
        end
        compare_value("game_state_o", game_state, GS_LOSE);
        watch_steps = 1'b0;
        put_key(`KEY_R, 1'b0);
        repeat (2) @(negedge clk);
        expect_reset_values();
    endtask

    task automatic back_pressure();
        int n;
        put_key(`KEY_R, 1'b0);
        repeat (2) @(negedge clk);
        compare_value("game_state_o", game_state, GS_PLAY);
        wait_for(PROBE_Y, REST_Y, FALL_LIMIT, "resting height after restart");
        repeat (2 * `FALL_PERIOD_START) @(negedge clk);
        watch_steps = 1'b1;
        min_y = REST_Y;
        send_key(`KEY_W, 1'b0);
        send_key(`KEY_D, 1'b0);
        send_key(`KEY_W, 1'b1);
        send_key(`KEY_D, 1'b1);
        key_valid_i = 1'b0;
        n = 0;
        while (min_y >= REST_Y && n < 2 * `RAMP_PIXELS * `JUMP_PERIOD_END) begin
            @(negedge clk);
            n++;
        end
        require_true(min_y < REST_Y, "no jump followed the W press");
        wait_for(PROBE_Y, REST_Y, 4 * `RAMP_PIXELS * (`JUMP_PERIOD_END + `FALL_PERIOD_START),
                 "landing after the jump");
        repeat (2) @(negedge clk);
        watch_still(8 * `MOVE_PERIOD, "player moved after all keys were released");
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        key_i       = '0;
        key_valid_i = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        watch_steps = 1'b0;
        min_y       = `SCREEN_H;
        prev_pos    = '0;
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        reset_and_start();
        landing_and_icing();
        walk_and_release();
        snowflake_score();
        monster_damage();
        back_pressure();
        finish_run();
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        n_errors++;
        $display("ERROR: run stopped by timeout after %0d cycles", cycle_cnt);
        finish_run();
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
ice_geom_pkg.sv
ice_game_pkg.sv
key_decoder.sv
ground_map.sv
player_motion.sv
pickup_tracker.sv
game_fsm.sv
ice_game_top.sv
tb_ice_game.sv

/* Bender.yml */
package:
  name: ice_game

sources:
  - include_dirs:
      - .
    files:
      - ice_geom_pkg.sv
      - ice_game_pkg.sv
      - key_decoder.sv
      - ground_map.sv
      - player_motion.sv
      - pickup_tracker.sv
      - game_fsm.sv
      - ice_game_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ice_game.sv
